// ==== files.f ====
hw/vga_pkg.sv
hw/vga_timing.sv
hw/upscale_addr.sv
hw/frame_buffer.sv
hw/pixel_out.sv
hw/vga_upscale_top.sv
verification/vga_upscale_asserts.sv
verification/tb_vga_upscale.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_vga_upscale
FILELIST  = files.f
BUILD_DIR = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
PASS_TEXT = sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_vga_upscale.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// testbench for vga_upscale_top, random frame fill and live writes
// pins compared against a raster model three clocks behind the counters
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_vga_upscale;

    localparam int AW         = vga_pkg::FB_ADDR_W;
    localparam int PW         = vga_pkg::PIX_W;
    localparam int FB_WORDS   = vga_pkg::SRC_WIDTH * vga_pkg::SRC_HEIGHT;  // 76800
    localparam int FRAME      = vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;       // 420000 clocks
    localparam int RUN_CYCLES = FB_WORDS + 2 * FRAME;
    localparam int TIMEOUT    = 1000000;   // run length plus margin
    localparam int HS_FIRST   = vga_pkg::H_DISPLAY + vga_pkg::H_FRONT;     // 656
    localparam int VS_FIRST   = vga_pkg::V_DISPLAY + vga_pkg::V_FRONT;     // 490
    localparam logic [26:0] RESET_PINS = {3'b110, 24'h0};  // syncs high, blanked, black

    logic                     CLK25;
    logic                     rst_n;
    logic                     wr_en;
    logic [AW-1:0]            wr_addr;
    logic [PW-1:0]            wr_data;
    logic                     hsync;
    logic                     vsync;
    logic                     blank_n;
    logic [vga_pkg::CH_W-1:0] red;
    logic [vga_pkg::CH_W-1:0] green;
    logic [vga_pkg::CH_W-1:0] blue;

    logic [PW-1:0] model_mem [FB_WORDS];  // mirror of the frame buffer
    logic [26:0]   exp_q [$];             // {hsync, vsync, blank_n, red, green, blue}
    int            pos_q [$];             // y*1024 + x, -1 for reset entries
    int            mx = 0;                // model raster position
    int            my = 0;
    int            rd_word = -1;          // word the ram reads at the next edge, -1 blanked
    int            errors = 0;
    int            checks = 0;
    int            live_writes = 0;
    int            cycles = 0;

    vga_upscale_top DUT (
        .CLK25   (CLK25),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .hsync   (hsync),
        .vsync   (vsync),
        .blank_n (blank_n),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    bind pixel_out vga_upscale_asserts u_asserts (
        .CLK25   (CLK25),
        .rst_n   (rst_n),
        .hsync   (hsync),
        .vsync   (vsync),
        .blank_n (blank_n),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

    always #50 CLK25 = ~CLK25;   // 10 MHz in sim, period 100 ns

    // run limit
    always @(posedge CLK25) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, run did not complete", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_field(input string name, input logic [7:0] want,
                               input logic [7:0] got, input string where);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH %s at %s: expected %h, got %h", name, where, want, got);
        end
    endtask

    // oldest prediction against the pins now
    task automatic compare_pins();
        logic [26:0] want;
        int          pos;
        string       where;
        want = exp_q.pop_front();
        pos  = pos_q.pop_front();
        if (pos < 0) begin
            where = "reset";
        end else begin
            where = $sformatf("x=%0d y=%0d", pos % 1024, pos / 1024);
        end
        check_field("hsync", {7'd0, want[26]}, {7'd0, hsync}, where);
        check_field("vsync", {7'd0, want[25]}, {7'd0, vsync}, where);
        check_field("blank_n", {7'd0, want[24]}, {7'd0, blank_n}, where);
        check_field("red", want[23:16], red, where);
        check_field("green", want[15:8], green, where);
        check_field("blue", want[7:0], blue, where);
    endtask

    // loader strobe for cycle n, then prediction for the current raster position
    task automatic drive_and_predict(input int n);
        logic [PW-1:0] word;
        logic          hs;
        logic          vs;
        logic          vis;
        int            addr;
        logic [7:0]    r;
        logic [7:0]    g;
        logic [7:0]    b;
        wr_en = 1'b0;
        if (n < FB_WORDS) begin                    // sequential fill, frame one
            wr_en   = 1'b1;
            wr_addr = AW'(n);
            wr_data = PW'($urandom);
        end else if (n >= FRAME && n < 2 * FRAME && ($urandom % 8) == 0) begin
            wr_en   = 1'b1;                        // sparse live writes, frame two
            wr_addr = AW'($urandom % FB_WORDS);
            if (rd_word >= 0 && ($urandom % 4) == 0) begin
                wr_addr = AW'(rd_word);            // hit the word read at the same edge
            end
            wr_data = PW'($urandom);
            live_writes++;
        end
        if (wr_en) model_mem[wr_addr] = wr_data;  // ram holds it after the next edge
        hs   = !(mx >= HS_FIRST && mx < HS_FIRST + vga_pkg::H_SYNC);
        vs   = !(my >= VS_FIRST && my < VS_FIRST + vga_pkg::V_SYNC);
        vis  = (mx < vga_pkg::H_DISPLAY) && (my < vga_pkg::V_DISPLAY);
        addr = (my / 2) * vga_pkg::SRC_WIDTH + mx / 2;
        word = '0;                                 // black outside the picture
        if (vis) word = model_mem[addr];
        rd_word = vis ? addr : -1;                 // read by the ram with the next strobe
        r = {word[15:11], word[15:13]};            // 5 bits, then top 3 again
        g = {word[10:5], word[10:9]};
        b = {word[4:0], word[4:2]};
        exp_q.push_back({hs, vs, vis, r, g, b});
        pos_q.push_back(my * 1024 + mx);
        if (mx == vga_pkg::H_TOTAL - 1) begin
            mx = 0;
            my = (my == vga_pkg::V_TOTAL - 1) ? 0 : my + 1;
        end else begin
            mx++;
        end
    endtask

    initial begin
        CLK25   = 1'b0;
        rst_n   = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        void'($urandom(32'hf0df));
        repeat (8) begin                           // reset held for 8 clocks
            @(posedge CLK25);
            #1;
            exp_q.push_back(RESET_PINS);
            pos_q.push_back(-1);
            compare_pins();
        end
        rst_n = 1'b1;
        // first two clocks out of reset still show reset values at the pins
        repeat (2) begin
            exp_q.push_back(RESET_PINS);
            pos_q.push_back(-1);
        end
        drive_and_predict(0);
        for (int n = 1; n < RUN_CYCLES; n++) begin
            @(posedge CLK25);
            #1;
            compare_pins();
            drive_and_predict(n);
        end
        $display("checks %0d, errors %0d, assertion failures %0d, live writes %0d",
                 checks, errors, DUT.u_out.u_asserts.fail_count, live_writes);
        if (errors == 0 && DUT.u_out.u_asserts.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verification/vga_upscale_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// sync width, blanking and vsync alignment rules on the vga pins
// bound into pixel_out
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vga_upscale_asserts (
    input logic                     CLK25,
    input logic                     rst_n,
    input logic                     hsync,
    input logic                     vsync,
    input logic                     blank_n,
    input logic [vga_pkg::CH_W-1:0] red,
    input logic [vga_pkg::CH_W-1:0] green,
    input logic [vga_pkg::CH_W-1:0] blue
);

    localparam int CW       = vga_pkg::CNT_W;
    localparam int HS_FIRST = vga_pkg::H_DISPLAY + vga_pkg::H_FRONT;   // x where hsync falls

    int         width_fails = 0;
    int         long_fails = 0;
    int         blank_fails = 0;
    int         vs_fails = 0;
    int         fail_count;
    logic       hsync_q;      // pins one clock back
    logic       vsync_q;
    logic [CW-1:0] low_cnt;   // clocks hsync has been low
    logic [CW-1:0] col;       // x of the pins, recovered from hsync
    logic       col_valid;

    assign fail_count = width_fails + long_fails + blank_fails + vs_fails;

    always_ff @(posedge CLK25) begin
        if (!rst_n) begin
            hsync_q   <= 1'b1;
            vsync_q   <= 1'b1;
            low_cnt   <= '0;
            col       <= '0;
            col_valid <= 1'b0;
        end else begin
            hsync_q <= hsync;
            vsync_q <= vsync;
            low_cnt <= hsync ? '0 : low_cnt + 1'b1;
            if (hsync_q && !hsync) begin            // falling edge marks x=656
                col       <= CW'(HS_FIRST + 1);
                col_valid <= 1'b1;
            end else begin
                col <= (col == CW'(vga_pkg::H_TOTAL - 1)) ? '0 : col + 1'b1;
            end
        end
    end

    hsync_width: assert property (@(posedge CLK25) disable iff (!rst_n)
        (hsync && !hsync_q) |-> (low_cnt == CW'(vga_pkg::H_SYNC)))
        else begin
            $error("hsync pulse ended after %0d clocks", low_cnt);
            width_fails++;
        end

    hsync_not_long: assert property (@(posedge CLK25) disable iff (!rst_n)
        !hsync |-> (low_cnt < CW'(vga_pkg::H_SYNC)))
        else begin
            $error("hsync held low too long");
            long_fails++;
        end

    blank_black: assert property (@(posedge CLK25) disable iff (!rst_n)
        !blank_n |-> (red == '0 && green == '0 && blue == '0))
        else begin
            $error("colour not black while blanked");
            blank_fails++;
        end

    vsync_line_start: assert property (@(posedge CLK25) disable iff (!rst_n || !col_valid)
        (vsync != vsync_q) |-> (col == '0))
        else begin
            $error("vsync changed at x=%0d", col);
            vs_fails++;
        end

endmodule

// ==== hw/vga_upscale_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// vga 640x480 output of a 320x240 rgb565 frame buffer, 2x scaled
// pins trail the raster counters by three clocks
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vga_upscale_top (
    input  logic                          CLK25,     // pixel clock
    input  logic                          rst_n,
    input  logic                          wr_en,     // loader strobe
    input  logic [vga_pkg::FB_ADDR_W-1:0] wr_addr,
    input  logic [vga_pkg::PIX_W-1:0]     wr_data,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          blank_n,
    output logic [vga_pkg::CH_W-1:0]      red,
    output logic [vga_pkg::CH_W-1:0]      green,
    output logic [vga_pkg::CH_W-1:0]      blue
);

    logic [vga_pkg::CNT_W-1:0]     h_pos;
    logic [vga_pkg::CNT_W-1:0]     v_pos;
    logic                          hsync_early;
    logic                          vsync_early;
    logic                          visible_early;
    logic [vga_pkg::FB_ADDR_W-1:0] rd_addr;
    logic [vga_pkg::PIX_W-1:0]     rd_data;

    // raster position, stage t
    vga_timing #(
        .H_DISPLAY (vga_pkg::H_DISPLAY),
        .H_FRONT   (vga_pkg::H_FRONT),
        .H_SYNC    (vga_pkg::H_SYNC),
        .H_TOTAL   (vga_pkg::H_TOTAL),
        .V_DISPLAY (vga_pkg::V_DISPLAY),
        .V_FRONT   (vga_pkg::V_FRONT),
        .V_SYNC    (vga_pkg::V_SYNC),
        .V_TOTAL   (vga_pkg::V_TOTAL)
    ) u_timing (
        .CLK25         (CLK25),
        .rst_n         (rst_n),
        .h_pos         (h_pos),
        .v_pos         (v_pos),
        .hsync_early   (hsync_early),
        .vsync_early   (vsync_early),
        .visible_early (visible_early)
    );

    // read address at t+1
    upscale_addr #(
        .SRC_WIDTH (vga_pkg::SRC_WIDTH),
        .H_DISPLAY (vga_pkg::H_DISPLAY),
        .V_DISPLAY (vga_pkg::V_DISPLAY)
    ) u_addr (
        .CLK25   (CLK25),
        .rst_n   (rst_n),
        .h_pos   (h_pos),
        .v_pos   (v_pos),
        .rd_addr (rd_addr)
    );

    // pixel word at t+2
    frame_buffer #(
        .DEPTH (vga_pkg::SRC_WIDTH * vga_pkg::SRC_HEIGHT)
    ) u_fb (
        .CLK25   (CLK25),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // pins at t+3
    pixel_out u_out (
        .CLK25         (CLK25),
        .rst_n         (rst_n),
        .hsync_early   (hsync_early),
        .vsync_early   (vsync_early),
        .visible_early (visible_early),
        .rd_data       (rd_data),
        .hsync         (hsync),
        .vsync         (vsync),
        .blank_n       (blank_n),
        .red           (red),
        .green         (green),
        .blue          (blue)
    );

endmodule

// ==== hw/pixel_out.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// output stage, lines syncs and blanking up with ram data
// expands rgb565 to three 8-bit dac channels
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pixel_out (
    input  logic                      CLK25,
    input  logic                      rst_n,
    input  logic                      hsync_early,    // from timing, active low
    input  logic                      vsync_early,
    input  logic                      visible_early,
    input  logic [vga_pkg::PIX_W-1:0] rd_data,        // frame buffer word
    output logic                      hsync,          // active low
    output logic                      vsync,          // active low
    output logic                      blank_n,        // high in the picture
    output logic [vga_pkg::CH_W-1:0]  red,
    output logic [vga_pkg::CH_W-1:0]  green,
    output logic [vga_pkg::CH_W-1:0]  blue
);

    logic hsync_d;     // flags one stage late, in step with rd_data
    logic vsync_d;
    logic visible_d;

    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;

    assign r5 = rd_data[15:11];
    assign g6 = rd_data[10:5];
    assign b5 = rd_data[4:0];

    // delay stage matching the ram read latency
    always_ff @(posedge CLK25) begin
        if (!rst_n) begin
            hsync_d   <= 1'b1;
            vsync_d   <= 1'b1;
            visible_d <= 1'b0;
        end else begin
            hsync_d   <= hsync_early;
            vsync_d   <= vsync_early;
            visible_d <= visible_early;
        end
    end

    // output registers, colour forced to black when blanked
    always_ff @(posedge CLK25) begin
        if (!rst_n) begin
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            blank_n <= 1'b0;
            red     <= '0;
            green   <= '0;
            blue    <= '0;
        end else begin
            hsync   <= hsync_d;
            vsync   <= vsync_d;
            blank_n <= visible_d;
            red     <= visible_d ? {r5, r5[4:2]} : '0;   // msb replication
            green   <= visible_d ? {g6, g6[5:4]} : '0;
            blue    <= visible_d ? {b5, b5[4:2]} : '0;
        end
    end

endmodule

// ==== hw/frame_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// rgb565 frame store, one write port and one registered read port
// filled by the external loader while the display reads
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module frame_buffer #(
    parameter int DEPTH = 76800   // words, 320x240
) (
    input  logic                          CLK25,
    input  logic                          wr_en,     // one word per cycle
    input  logic [vga_pkg::FB_ADDR_W-1:0] wr_addr,
    input  logic [vga_pkg::PIX_W-1:0]     wr_data,
    input  logic [vga_pkg::FB_ADDR_W-1:0] rd_addr,
    output logic [vga_pkg::PIX_W-1:0]     rd_data    // one clock after rd_addr
);

    logic [vga_pkg::PIX_W-1:0] mem [DEPTH];

    // write side, no handshake
    always_ff @(posedge CLK25) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read side
    // same-address write in this cycle is not visible yet, old word comes out
    always_ff @(posedge CLK25) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== hw/upscale_addr.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// 2x nearest-neighbour address mapping, display xy to source word
// address is registered, valid one clock after the position
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module upscale_addr #(
    parameter int SRC_WIDTH = 320,
    parameter int H_DISPLAY = 640,
    parameter int V_DISPLAY = 480
) (
    input  logic                          CLK25,
    input  logic                          rst_n,
    input  logic [vga_pkg::CNT_W-1:0]     h_pos,
    input  logic [vga_pkg::CNT_W-1:0]     v_pos,
    output logic [vga_pkg::FB_ADDR_W-1:0] rd_addr   // to frame buffer read port
);

    localparam int CW = vga_pkg::CNT_W;
    localparam int AW = vga_pkg::FB_ADDR_W;

    logic [CW-2:0] src_x;       // 0..319
    logic [CW-2:0] src_y;       // 0..239
    logic [AW-1:0] line_base;   // first word of the source row
    logic [AW-1:0] addr_next;
    logic          visible;

    // halve both coordinates, each source pixel spans 2x2
    assign src_x = h_pos[CW-1:1];
    assign src_y = v_pos[CW-1:1];

    // row times width, constant multiply
    assign line_base = AW'(src_y) * AW'(SRC_WIDTH);
    assign addr_next = line_base + AW'(src_x);

    // local visibility check, same window as the timing block
    assign visible = (h_pos < CW'(H_DISPLAY)) && (v_pos < CW'(V_DISPLAY));

    always_ff @(posedge CLK25) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (visible) begin
            rd_addr <= addr_next;
        end else begin
            rd_addr <= '0;   // parked at word 0 during blanking
        end
    end

endmodule

// ==== hw/vga_timing.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// 640x480 raster counters with registered sync and visible flags
// flags trail the counter position by one clock
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_DISPLAY = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_TOTAL   = 800,
    parameter int V_DISPLAY = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_TOTAL   = 525
) (
    input  logic                      CLK25,
    input  logic                      rst_n,
    output logic [vga_pkg::CNT_W-1:0] h_pos,          // current pixel in line
    output logic [vga_pkg::CNT_W-1:0] v_pos,          // current line in frame
    output logic                      hsync_early,    // active low
    output logic                      vsync_early,    // active low
    output logic                      visible_early
);

    localparam int CW = vga_pkg::CNT_W;

    // sync windows, first and last counter value of the pulse
    localparam int H_SYNC_START = H_DISPLAY + H_FRONT;           // 656
    localparam int H_SYNC_END   = H_DISPLAY + H_FRONT + H_SYNC;  // 752, exclusive
    localparam int V_SYNC_START = V_DISPLAY + V_FRONT;           // 490
    localparam int V_SYNC_END   = V_DISPLAY + V_FRONT + V_SYNC;  // 492, exclusive

    logic h_last;   // last pixel of a line
    logic v_last;   // last line of a frame
    logic h_in_sync;
    logic v_in_sync;
    logic in_display;

    assign h_last = (h_pos == CW'(H_TOTAL - 1));
    assign v_last = (v_pos == CW'(V_TOTAL - 1));

    // pixel and line counters
    always_ff @(posedge CLK25) begin
        if (!rst_n) begin
            h_pos <= '0;
            v_pos <= '0;
        end else if (h_last) begin
            h_pos <= '0;                             // wrap line
            v_pos <= v_last ? '0 : v_pos + 1'b1;     // next line or new frame
        end else begin
            h_pos <= h_pos + 1'b1;
        end
    end

    // window decodes on the current position
    assign h_in_sync  = (h_pos >= CW'(H_SYNC_START)) && (h_pos < CW'(H_SYNC_END));
    assign v_in_sync  = (v_pos >= CW'(V_SYNC_START)) && (v_pos < CW'(V_SYNC_END));
    assign in_display = (h_pos < CW'(H_DISPLAY)) && (v_pos < CW'(V_DISPLAY));

    // registered flags, one clock behind h_pos/v_pos
    always_ff @(posedge CLK25) begin
        if (!rst_n) begin
            hsync_early   <= 1'b1;   // inactive
            vsync_early   <= 1'b1;
            visible_early <= 1'b0;
        end else begin
            hsync_early   <= ~h_in_sync;
            vsync_early   <= ~v_in_sync;
            visible_early <= in_display;
        end
    end

endmodule

// ==== hw/vga_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// shared VGA timing, frame-buffer sizes and bus widths
// referenced by scoped name from design and testbench
// ~~~~~~~~~~~~~~~~~~~~
package vga_pkg;

    // horizontal timing, in pixel clocks
    localparam int H_DISPLAY = 640;  // visible pixels per line
    localparam int H_FRONT   = 16;   // front porch
    localparam int H_SYNC    = 96;   // sync pulse
    localparam int H_BACK    = 48;   // back porch
    localparam int H_TOTAL   = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;  // 800

    // vertical timing, in lines
    localparam int V_DISPLAY = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;
    localparam int V_TOTAL   = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;  // 525

    // source picture, half size in each direction
    localparam int SRC_WIDTH  = 320;
    localparam int SRC_HEIGHT = 240;

    // position counters, enough for 0..799
    localparam int CNT_W = 10;

    // 320*240 = 76800 words, needs 17 bits
    localparam int FB_ADDR_W = 17;

    // rgb565 pixel word
    localparam int PIX_W = 16;

    // one dac channel
    localparam int CH_W = 8;

    // field positions inside an rgb565 word
    //   [15:11] red, [10:5] green, [4:0] blue
    // expansion to 8 bits is done by replicating the msbs

endpackage
